// File: files.f
+incdir+hdl
hdl/bp_pkg.sv
hdl/btb.sv
hdl/direction_predictor.sv
hdl/fetch_pc_gen.sv
hdl/branch_predictor_top.sv
verif/bp_sva.sv
verif/bp_tb.sv

// File: hdl/bp_macros.svh
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

//////////////////////////////
// Word size
//////////////////////////////
`define XLEN 32

//////////////////////////////
// Target buffer geometry
//////////////////////////////
// Index from PC[5:2], tag from PC[15:6]
`define BTB_SIZE 16
`define BTB_IDX_LEN 4
`define BTB_TAG_LEN 10

// Direction counters indexed by PC[6:2]
`define BHT_SIZE 32
`define BHT_IDX_LEN 5

// First fetch address out of reset
`define RESET_PC 32'h0000_1000

`endif

// File: hdl/bp_pkg.sv
`include "bp_macros.svh"

package bp_pkg;

   //////////////////////////////
   // Direction counter
   //////////////////////////////

   // Ordered so that taken is the upper half
   typedef enum logic [1:0] {
      STRONG_NT = 2'b00,
      WEAK_NT   = 2'b01,
      WEAK_T    = 2'b10,
      STRONG_T  = 2'b11
   } counter_state_t;

   //////////////////////////////
   // Front end buses
   //////////////////////////////

   // Guess for the current fetch PC
   typedef struct packed {
      logic             hit;
      logic             taken;
      logic [`XLEN-1:0] target;
   } prediction_t;

   // Branch outcome from execute
   typedef struct packed {
      logic             valid;
      logic [`XLEN-1:0] pc;
      logic             taken;
      logic [`XLEN-1:0] target;
   } resolve_t;

   // Correction on a mispredict
   typedef struct packed {
      logic             valid;
      logic [`XLEN-1:0] next_pc;
   } redirect_t;

endpackage

// File: hdl/branch_predictor_top.sv
`timescale 1ns/1ns
`include "bp_macros.svh"

module branch_predictor_top
   import bp_pkg::*;
(
   input  logic             clock,
   input  logic             reset,
   input  logic             fetch_en,
   input  resolve_t         resolve,
   input  redirect_t        redirect,
   output logic [`XLEN-1:0] fetch_pc,
   output prediction_t      pred
);

   logic             btb_hit;
   logic [`XLEN-1:0] btb_target;
   logic             dir_taken;
   logic             btb_write;

   // Only taken branches allocate a BTB entry
   assign btb_write = resolve.valid && resolve.taken;

   // Taken needs both a BTB hit and a taken counter
   assign pred = '{hit: btb_hit, taken: btb_hit && dir_taken, target: btb_target};

   fetch_pc_gen u_fetch_pc_gen (
      .clock    (clock),
      .reset    (reset),
      .fetch_en (fetch_en),
      .pred     (pred),
      .redirect (redirect),
      .fetch_pc (fetch_pc)
   );

   btb u_btb (
      .clock        (clock),
      .reset        (reset),
      .read_en      (fetch_en),
      .read_pc      (fetch_pc),
      .write_en     (btb_write),
      .write_pc     (resolve.pc),
      .write_target (resolve.target),
      .hit          (btb_hit),
      .target       (btb_target)
   );

   direction_predictor u_direction_predictor (
      .clock         (clock),
      .reset         (reset),
      .read_pc       (fetch_pc),
      .update        (resolve),
      .predict_taken (dir_taken)
   );

endmodule

// File: hdl/btb.sv
`timescale 1ns/1ns
`include "bp_macros.svh"

module btb (
   input  logic             clock,
   input  logic             reset,
   // Lookup port
   input  logic             read_en,
   input  logic [`XLEN-1:0] read_pc,
   // Update port
   input  logic             write_en,
   input  logic [`XLEN-1:0] write_pc,
   input  logic [`XLEN-1:0] write_target,
   output logic             hit,
   output logic [`XLEN-1:0] target
);

   // Direct mapped storage
   logic [`BTB_SIZE-1:0]    valid;
   logic [`BTB_TAG_LEN-1:0] tags [`BTB_SIZE];
   logic [`XLEN-1:0]        targets [`BTB_SIZE];

   logic [`BTB_IDX_LEN-1:0] read_idx;
   logic [`BTB_TAG_LEN-1:0] read_tag;
   logic [`BTB_IDX_LEN-1:0] write_idx;
   logic [`BTB_TAG_LEN-1:0] write_tag;

   // PC[15:6] is the tag and PC[5:2] the index
   assign {read_tag, read_idx}   = read_pc[`BTB_TAG_LEN+`BTB_IDX_LEN+1:2];
   assign {write_tag, write_idx} = write_pc[`BTB_TAG_LEN+`BTB_IDX_LEN+1:2];

   //////////////////////////////
   // Combinational lookup
   //////////////////////////////
   assign hit    = read_en && valid[read_idx] && (tags[read_idx] == read_tag);
   // Target reads zero on a miss
   assign target = hit ? targets[read_idx] : '0;

   //////////////////////////////
   // Update
   //////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         valid <= '0;
      end else if (write_en) begin
         valid[write_idx] <= 1'b1;
      end
   end

   // Old contents stay visible to a same-cycle read
   always_ff @(posedge clock) begin
      if (write_en) begin
         tags[write_idx]    <= write_tag;
         targets[write_idx] <= write_target;
      end
   end

endmodule

// File: hdl/direction_predictor.sv
`timescale 1ns/1ns
`include "bp_macros.svh"

module direction_predictor
   import bp_pkg::*;
(
   input  logic             clock,
   input  logic             reset,
   input  logic [`XLEN-1:0] read_pc,
   input  resolve_t         update,
   output logic             predict_taken
);

   counter_state_t counters [`BHT_SIZE];

   logic [`BHT_IDX_LEN-1:0] read_idx;
   logic [`BHT_IDX_LEN-1:0] update_idx;
   counter_state_t          read_state;
   counter_state_t          cur_state;
   counter_state_t          next_state;

   // Both sides indexed by PC[6:2]
   assign read_idx   = read_pc[`BHT_IDX_LEN+1:2];
   assign update_idx = update.pc[`BHT_IDX_LEN+1:2];

   //////////////////////////////
   // Prediction
   //////////////////////////////
   assign read_state    = counters[read_idx];
   assign predict_taken = (read_state == WEAK_T) || (read_state == STRONG_T);

   //////////////////////////////
   // Training
   //////////////////////////////
   assign cur_state = counters[update_idx];

   // One step toward the outcome, saturating at both ends
   always_comb begin
      next_state = cur_state;
      case (cur_state)
         STRONG_NT: next_state = update.taken ? WEAK_NT  : STRONG_NT;
         WEAK_NT:   next_state = update.taken ? WEAK_T   : STRONG_NT;
         WEAK_T:    next_state = update.taken ? STRONG_T : WEAK_NT;
         STRONG_T:  next_state = update.taken ? STRONG_T : WEAK_T;
         default:   next_state = WEAK_NT;
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         // Start every entry weakly not taken
         for (int i = 0; i < `BHT_SIZE; i++) begin
            counters[i] <= WEAK_NT;
         end
      end else if (update.valid) begin
         counters[update_idx] <= next_state;
      end
   end

endmodule

// File: hdl/fetch_pc_gen.sv
`timescale 1ns/1ns
`include "bp_macros.svh"

module fetch_pc_gen
   import bp_pkg::*;
(
   input  logic             clock,
   input  logic             reset,
   input  logic             fetch_en,
   input  prediction_t      pred,
   input  redirect_t        redirect,
   output logic [`XLEN-1:0] fetch_pc
);

   logic [`XLEN-1:0] seq_pc;
   logic [`XLEN-1:0] next_pc;

   // Next sequential word
   assign seq_pc = fetch_pc + `XLEN'(4);

   //////////////////////////////
   // Next PC select
   //////////////////////////////

   // Redirect beats prediction, prediction beats sequential
   always_comb begin
      if (redirect.valid) begin
         next_pc = redirect.next_pc;
      end else if (fetch_en && pred.taken) begin
         next_pc = pred.target;
      end else if (fetch_en) begin
         next_pc = seq_pc;
      end else begin
         // Stalled fetch holds its PC
         next_pc = fetch_pc;
      end
   end

   //////////////////////////////
   // PC register
   //////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         fetch_pc <= `RESET_PC;
      end else begin
         fetch_pc <= next_pc;
      end
   end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f files.f --top-module bp_tb -o bp_sim \
   && ./obj_dir/bp_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log 2>/dev/null && echo "Simulation PASSED" && exit 0 \
   || { echo "Simulation FAILED"; exit 1; }

// File: verif/bp_sva.sv
`timescale 1ns/1ns
`include "bp_macros.svh"

module bp_sva
   import bp_pkg::*;
(
   input logic             clock,
   input logic             reset,
   input prediction_t      pred,
   input redirect_t        redirect,
   input logic [`XLEN-1:0] fetch_pc
);

   // Taken guess only on a BTB hit
   taken_needs_hit: assert property (@(posedge clock) disable iff (reset)
      pred.taken |-> pred.hit)
      else $error("pred.taken is set without pred.hit");

   // Miss reads a zero target
   miss_zero_target: assert property (@(posedge clock) disable iff (reset)
      !pred.hit |-> (pred.target == '0))
      else $error("pred.target is not zero on a miss");

   // Redirect always lands on the next cycle
   redirect_wins: assert property (@(posedge clock) disable iff (reset)
      redirect.valid |=> (fetch_pc == $past(redirect.next_pc)))
      else $error("fetch_pc did not follow redirect.next_pc");

endmodule

bind branch_predictor_top bp_sva sva0 (
   .clock    (clock),
   .reset    (reset),
   .pred     (pred),
   .redirect (redirect),
   .fetch_pc (fetch_pc)
);

// File: verif/bp_tb.sv
`timescale 1ns/1ns
`include "bp_macros.svh"

module bp_tb
   import bp_pkg::*;
();

   // Reset, directed steps and the drain at the end
   localparam int DIRECTED_CYCLES = 24;
   localparam int RANDOM_CYCLES   = 400;
   localparam int STIM_CYCLES     = DIRECTED_CYCLES + RANDOM_CYCLES;
   localparam int TIMEOUT_CYCLES  = 4 * STIM_CYCLES + 50;

   // Alias shares the index of BR_PC with another tag
   localparam logic [`XLEN-1:0] BR_PC     = 32'h0000_1010;
   localparam logic [`XLEN-1:0] BR_TARGET = 32'h0000_2000;
   localparam logic [`XLEN-1:0] ALIAS_PC  = 32'h0000_1050;
   localparam logic [`XLEN-1:0] FAR_PC    = 32'h0000_1100;

   logic             clock = 1'b0;
   logic             reset;
   logic             fetch_en;
   resolve_t         resolve;
   redirect_t        redirect;
   logic [`XLEN-1:0] fetch_pc;
   prediction_t      pred;

   // Shadow state of the front end
   logic                    model_valid [`BTB_SIZE];
   logic [`BTB_TAG_LEN-1:0] model_tag [`BTB_SIZE];
   logic [`XLEN-1:0]        model_target [`BTB_SIZE];
   int                      model_ctr [`BHT_SIZE];
   logic [`XLEN-1:0]        model_pc;

   logic [31:0] rng_state   = 32'he482;
   int          cycle_count = 0;

   branch_predictor_top dut0 (
      .clock    (clock),
      .reset    (reset),
      .fetch_en (fetch_en),
      .resolve  (resolve),
      .redirect (redirect),
      .fetch_pc (fetch_pc),
      .pred     (pred)
   );

   initial begin
      forever #2 clock = ~clock;
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Index PC[5:2], tag PC[15:6], counter index PC[6:2]
   function automatic prediction_t predict_model(input logic [`XLEN-1:0] pc, input logic en);
      prediction_t p;
      int          bi;
      int          ci;
      bi = int'(pc[5:2]);
      ci = int'(pc[6:2]);
      p  = '0;
      if (en && model_valid[bi] && (model_tag[bi] == pc[15:6])) begin
         p.hit    = 1'b1;
         p.taken  = (model_ctr[ci] >= 2);
         p.target = model_target[bi];
      end
      return p;
   endfunction

   function automatic logic [`XLEN-1:0] next_pc_model(input logic [`XLEN-1:0] pc,
                                                      input logic en,
                                                      input prediction_t p,
                                                      input redirect_t red);
      if (red.valid) return red.next_pc;
      if (en && p.taken) return p.target;
      if (en) return pc + 32'd4;
      return pc;
   endfunction

   task automatic model_reset();
      model_pc = `RESET_PC;
      for (int i = 0; i < `BTB_SIZE; i++) begin
         model_valid[i] = 1'b0;
      end
      // Weakly not taken
      for (int i = 0; i < `BHT_SIZE; i++) begin
         model_ctr[i] = 1;
      end
   endtask

   // One rising edge with the inputs now on the bus
   task automatic model_step();
      prediction_t p;
      int          bi;
      int          ci;
      p        = predict_model(model_pc, fetch_en);
      model_pc = next_pc_model(model_pc, fetch_en, p, redirect);
      if (resolve.valid) begin
         ci = int'(resolve.pc[6:2]);
         if (resolve.taken && model_ctr[ci] < 3) model_ctr[ci]++;
         if (!resolve.taken && model_ctr[ci] > 0) model_ctr[ci]--;
         if (resolve.taken) begin
            bi               = int'(resolve.pc[5:2]);
            model_valid[bi]  = 1'b1;
            model_tag[bi]    = resolve.pc[15:6];
            model_target[bi] = resolve.target;
         end
      end
   endtask

   //////////////////////////////
   // Compare tasks
   //////////////////////////////
   task automatic check_pc(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected,
                           input string what);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
         $display("Testbench failed");
         $fatal(1, "stopping on first mismatch");
      end
   endtask

   task automatic check_pred(input prediction_t actual, input prediction_t expected,
                             input string what);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected hit=%0b taken=%0b target=%h, got %0b %0b %h",
                  $time, what, expected.hit, expected.taken, expected.target,
                  actual.hit, actual.taken, actual.target);
         $display("Testbench failed");
         $fatal(1, "stopping on first mismatch");
      end
   endtask

   // Compare on every falling edge before the stimulus lands
   initial begin
      forever begin
         @(negedge clock);
         if (reset) model_reset();
         else model_step();
         check_pc(fetch_pc, model_pc, "fetch_pc vs model");
         check_pred(pred, predict_model(model_pc, fetch_en), "pred vs model");
      end
   end

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clock);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $fatal(1, "timeout");
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   function automatic resolve_t resolve_of(input logic [`XLEN-1:0] pc, input logic taken,
                                           input logic [`XLEN-1:0] target);
      return '{valid: 1'b1, pc: pc, taken: taken, target: target};
   endfunction

   function automatic redirect_t redirect_to(input logic [`XLEN-1:0] pc);
      return '{valid: 1'b1, next_pc: pc};
   endfunction

   // Apply inputs now, return at the next falling edge
   task automatic drive(input logic en, input resolve_t res, input redirect_t red);
      fetch_en <= en;
      resolve  <= res;
      redirect <= red;
      @(negedge clock);
   endtask

   task automatic check_now(input logic [`XLEN-1:0] exp_pc, input prediction_t exp_pred,
                            input string what);
      check_pc(fetch_pc, exp_pc, what);
      check_pred(pred, exp_pred, what);
   endtask

   initial begin
      logic [31:0] r1;
      logic [31:0] r2;
      resolve_t    res;
      redirect_t   red;
      reset    = 1'b1;
      fetch_en = 1'b0;
      resolve  = '0;
      redirect = '0;
      repeat (2) @(negedge clock);
      check_now(`RESET_PC, '0, "after reset");
      reset <= 1'b0;

      // Sequential fetch and stall
      repeat (4) drive(1'b1, '0, '0);
      check_now(BR_PC, '0, "sequential fetch");
      repeat (3) drive(1'b0, '0, '0);
      check_now(BR_PC, '0, "stalled fetch");

      // Learn a taken branch
      drive(1'b0, resolve_of(BR_PC, 1'b1, BR_TARGET), '0);
      drive(1'b1, '0, redirect_to(BR_PC));
      check_now(BR_PC, '{hit: 1'b1, taken: 1'b1, target: BR_TARGET}, "hit after taken resolve");
      drive(1'b1, '0, '0);
      check_now(BR_TARGET, '0, "jump to target");

      // Same index, other tag
      drive(1'b1, '0, redirect_to(ALIAS_PC));
      check_now(ALIAS_PC, '0, "alias miss");
      drive(1'b1, '0, '0);
      check_now(ALIAS_PC + 32'd4, '0, "alias sequential");

      // Train down to strongly not taken, then back up
      repeat (3) drive(1'b0, resolve_of(BR_PC, 1'b0, BR_TARGET), '0);
      drive(1'b1, '0, redirect_to(BR_PC));
      check_now(BR_PC, '{hit: 1'b1, taken: 1'b0, target: BR_TARGET}, "saturated not taken");
      drive(1'b1, resolve_of(BR_PC, 1'b1, BR_TARGET), redirect_to(BR_PC));
      check_now(BR_PC, '{hit: 1'b1, taken: 1'b0, target: BR_TARGET}, "one taken step");
      drive(1'b1, resolve_of(BR_PC, 1'b1, BR_TARGET), redirect_to(BR_PC));
      check_now(BR_PC, '{hit: 1'b1, taken: 1'b1, target: BR_TARGET}, "two taken steps");

      // Redirect beats a predicted taken target
      drive(1'b1, '0, redirect_to(FAR_PC));
      check_now(FAR_PC, '0, "redirect priority");
      drive(1'b0, '0, '0);

      // Random traffic in a small address window
      repeat (RANDOM_CYCLES) begin
         r1  = next_rand();
         r2  = next_rand();
         res = resolve_of(32'h0000_1000 | {24'h0, r1[7:2], 2'b00}, r1[8],
                          32'h0000_1000 | {24'h0, r2[7:2], 2'b00});
         res.valid = r1[9];
         red = (r2[16:14] == 3'd0) ? redirect_to(32'h0000_1000 | {24'h0, r2[13:8], 2'b00})
                                   : '0;
         drive(r1[10] | r1[11], res, red);
      end
      drive(1'b0, '0, '0);
      @(negedge clock);

      $display("Testbench passed");
      $finish;
   end

endmodule
